// File: rtl/credit_link_pkg.sv
// Shared types for the credit link; credit_t covers pools of at most 16 credits
package credit_link_pkg;

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------

  // One flit of payload
  typedef logic [15:0] flit_t;

  // Credit count, 0 up to the largest pool (16)
  typedef logic [4:0] credit_t;

  // Size of one increment or decrement, at most 7
  typedef logic [2:0] change_t;

  // APB byte address
  typedef logic [7:0] reg_addr_t;

  // Sent-flit counter, wraps silently
  typedef logic [31:0] count_t;

  // --------------------------------------------------
  // Register map
  // --------------------------------------------------

  localparam reg_addr_t ADDR_CTRL     = 8'h00;
  localparam reg_addr_t ADDR_INIT     = 8'h04;
  localparam reg_addr_t ADDR_WITHHOLD = 8'h08;
  localparam reg_addr_t ADDR_STATUS   = 8'h0C;
  localparam reg_addr_t ADDR_SENT     = 8'h10;

  // Receiver credit return FSM
  typedef enum logic {
    ret_idle,
    ret_send
  } return_state_t;

endpackage

// File: rtl/credit_counter.sv
// Credit pool; caller keeps value within MAX_VALUE, amounts above MAX_CHANGE are clipped
`timescale 1ns/10ps

module credit_counter import credit_link_pkg::*; #(
  // Largest value the pool may hold
  parameter int MAX_VALUE  = 8,
  // Largest single increment or decrement
  parameter int MAX_CHANGE = 4
) (
  input  logic    clk,
  // Loads initial_value, synchronous
  input  logic    rst,
  input  logic    incr_valid,
  input  change_t incr,
  input  logic    decr_valid,
  input  change_t decr,
  input  credit_t initial_value,
  input  credit_t withhold,
  output credit_t value,
  output credit_t available,
  output logic    decr_ready
);

  // --------------------------------------------------
  // Amount clipping
  // --------------------------------------------------

  change_t incr_clip;
  change_t decr_clip;
  credit_t incr_amt;
  credit_t value_plus_incr;
  credit_t value_dec;
  credit_t value_next;

  // Guard against amounts wider than the pool was sized for
  assign incr_clip = (incr > change_t'(MAX_CHANGE)) ? change_t'(MAX_CHANGE) : incr;
  assign decr_clip = (decr > change_t'(MAX_CHANGE)) ? change_t'(MAX_CHANGE) : decr;

  assign incr_amt = incr_valid ? credit_t'(incr_clip) : '0;

  // --------------------------------------------------
  // Available credit
  // --------------------------------------------------

  // Returning credits count in the same cycle they arrive
  assign value_plus_incr = value + incr_amt;

  // Withhold larger than the pool leaves nothing available
  assign available = (value_plus_incr > withhold) ? value_plus_incr - withhold : '0;

  // Depends on the amount only, never on decr_valid
  assign decr_ready = credit_t'(decr_clip) <= available;

  // --------------------------------------------------
  // Next value
  // --------------------------------------------------

  // Decrement never exceeds available so no underflow here
  assign value_dec = value_plus_incr -
                     ((decr_valid && decr_ready) ? credit_t'(decr_clip) : '0);

  // Saturate at the pool size if the caller over-returns
  assign value_next = (value_dec > credit_t'(MAX_VALUE)) ? credit_t'(MAX_VALUE) : value_dec;

  always_ff @(posedge clk) begin
    if (rst) begin
      value <= initial_value;
    end else begin
      value <= value_next;
    end
  end

endmodule

// File: rtl/credit_sender.sv
// Flit sender; launches one cycle after acceptance, clear only while the link is idle
`timescale 1ns/10ps

module credit_sender import credit_link_pkg::*; #(
  // Pool size, at most 16
  parameter int CREDITS    = 8,
  // Largest credit batch from the receiver
  parameter int MAX_RETURN = 4
) (
  input  logic    clk,
  input  logic    rst,
  // Soft clear, reloads init_credits
  input  logic    clear,
  input  logic    in_valid,
  input  flit_t   in_data,
  output logic    in_ready,
  input  logic    cred_valid,
  input  change_t cred_count,
  input  credit_t init_credits,
  input  credit_t withhold,
  output logic    link_valid,
  output flit_t   link_data,
  output credit_t value,
  output credit_t available,
  output count_t  sent_count
);

  logic flush;
  logic accept;

  // Hard and soft reset share one path
  assign flush = rst | clear;

  // --------------------------------------------------
  // Credit pool
  // --------------------------------------------------

  // One credit per flit, returns come in as increments
  credit_counter #(
    .MAX_VALUE  (CREDITS),
    .MAX_CHANGE (MAX_RETURN)
  ) u_pool (
    .clk           (clk),
    .rst           (flush),
    .incr_valid    (cred_valid),
    .incr          (cred_count),
    .decr_valid    (in_valid),
    .decr          (change_t'(1)),
    .initial_value (init_credits),
    .withhold      (withhold),
    .value         (value),
    .available     (available),
    .decr_ready    (in_ready)
  );

  assign accept = in_valid && in_ready;

  // --------------------------------------------------
  // Link launch
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (flush) begin
      link_valid <= 1'b0;
    end else begin
      link_valid <= accept;
    end
  end

  // Payload holds its last value between flits
  always_ff @(posedge clk) begin
    if (accept) begin
      link_data <= in_data;
    end
  end

  // Counts flits as they go onto the link
  always_ff @(posedge clk) begin
    if (flush) begin
      sent_count <= '0;
    end else if (link_valid) begin
      sent_count <= sent_count + count_t'(1);
    end
  end

endmodule

// File: rtl/credit_receiver.sv
// Flit receiver; buffer holds CREDITS flits and relies on the sender never overrunning it
`timescale 1ns/10ps

module credit_receiver import credit_link_pkg::*; #(
  // Buffer depth equal to the sender pool
  parameter int CREDITS    = 8,
  // Largest credit batch per return, from 1 to 7
  parameter int MAX_RETURN = 4
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    clear,
  input  logic    link_valid,
  input  flit_t   link_data,
  output logic    out_valid,
  output flit_t   out_data,
  input  logic    out_ready,
  output logic    cred_valid,
  output change_t cred_count
);

  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

  logic             flush;
  flit_t            mem [CREDITS];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          count;
  logic             pop;
  credit_t          pend_avail;
  logic             pend_valid;
  change_t          batch;
  return_state_t    ret_state;

  assign flush = rst | clear;

  // --------------------------------------------------
  // Circular buffer
  // --------------------------------------------------

  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr];
  assign pop       = out_valid && out_ready;

  // A link flit always has a credit and so a free slot behind it
  always_ff @(posedge clk) begin
    if (link_valid) begin
      mem[wr_ptr] <= link_data;
    end
  end

  always_ff @(posedge clk) begin
    if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at CREDITS, which need not be a power of two
      if (link_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(CREDITS - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(CREDITS - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      count <= count + credit_t'(link_valid) - credit_t'(pop);
    end
  end

  // --------------------------------------------------
  // Pending credit pool
  // --------------------------------------------------

  // Starts empty and grows by one per pop
  credit_counter #(
    .MAX_VALUE  (CREDITS),
    .MAX_CHANGE (MAX_RETURN)
  ) u_pending (
    .clk           (clk),
    .rst           (flush),
    .incr_valid    (pop),
    .incr          (change_t'(1)),
    .decr_valid    (pend_valid),
    .decr          (batch),
    .initial_value ('0),
    .withhold      ('0),
    // Only the available amount matters here
    .value         (),
    .available     (pend_avail),
    // The batch never exceeds the pending amount so the decrement always fits
    .decr_ready    ()
  );

  // Batch is everything pending, capped at MAX_RETURN
  assign batch = (pend_avail > credit_t'(MAX_RETURN)) ? change_t'(MAX_RETURN)
                                                      : change_t'(pend_avail);

  // A pop this cycle already counts toward the batch
  assign pend_valid = pend_avail != '0;

  // --------------------------------------------------
  // Return FSM
  // --------------------------------------------------

  // ret_send marks the cycle a batch sits on the return channel
  always_ff @(posedge clk) begin
    if (flush) begin
      ret_state <= ret_idle;
    end else if (pend_valid) begin
      ret_state <= ret_send;
    end else begin
      ret_state <= ret_idle;
    end
  end

  // Count is only meaningful with cred_valid
  always_ff @(posedge clk) begin
    if (pend_valid) begin
      cred_count <= batch;
    end
  end

  assign cred_valid = ret_state == ret_send;

endmodule

// File: rtl/credit_apb_regs.sv
// APB register block; no wait states, INIT must not be written above CREDITS
`timescale 1ns/10ps

module credit_apb_regs import credit_link_pkg::*; #(
  // Reset value of INIT
  parameter int CREDITS = 8
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  reg_addr_t   paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  input  credit_t     value,
  input  credit_t     available,
  input  count_t      sent_count,
  output logic        clear,
  output credit_t     init_credits,
  output credit_t     withhold
);

  logic access;
  logic mapped;
  logic wr_en;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------

  // Access phase, one cycle per transfer
  assign access = psel && penable;

  always_comb begin
    case (paddr)
      ADDR_CTRL, ADDR_INIT, ADDR_WITHHOLD, ADDR_STATUS, ADDR_SENT: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  assign pready  = access;
  assign pslverr = access && !mapped;

  // Unmapped writes are dropped
  assign wr_en = access && pwrite && mapped;

  // --------------------------------------------------
  // Writable registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      init_credits <= credit_t'(CREDITS);
      withhold     <= '0;
      clear        <= 1'b0;
    end else begin
      // Soft clear lasts exactly one cycle
      clear <= wr_en && (paddr == ADDR_CTRL) && pwdata[0];
      if (wr_en && (paddr == ADDR_INIT)) begin
        init_credits <= pwdata[4:0];
      end
      if (wr_en && (paddr == ADDR_WITHHOLD)) begin
        withhold <= pwdata[4:0];
      end
    end
  end

  // --------------------------------------------------
  // Read mux
  // --------------------------------------------------

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      case (paddr)
        ADDR_INIT:     prdata = {27'b0, init_credits};
        ADDR_WITHHOLD: prdata = {27'b0, withhold};
        // Value low, available in bits 12:8
        ADDR_STATUS:   prdata = {19'b0, available, 3'b0, value};
        ADDR_SENT:     prdata = sent_count;
        // CTRL and holes read as zero
        default:       prdata = '0;
      endcase
    end
  end

endmodule

// File: rtl/credit_link_top.sv
// Credit link top; single clock domain, CREDITS at most 16, MAX_RETURN 1 to 7
`timescale 1ns/10ps

module credit_link_top import credit_link_pkg::*; #(
  parameter int CREDITS    = 8,
  parameter int MAX_RETURN = 4
) (
  input  logic        clk,
  input  logic        rst,
  // APB slave
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  reg_addr_t   paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  // Flit input
  input  logic        in_valid,
  input  flit_t       in_data,
  output logic        in_ready,
  // Flit output
  output logic        out_valid,
  output flit_t       out_data,
  input  logic        out_ready
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  logic    clear;
  credit_t init_credits;
  credit_t withhold;
  credit_t value;
  credit_t available;
  count_t  sent_count;
  logic    link_valid;
  flit_t   link_data;
  logic    cred_valid;
  change_t cred_count;

  credit_apb_regs #(
    .CREDITS (CREDITS)
  ) u_regs (
    .clk          (clk),
    .rst          (rst),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .value        (value),
    .available    (available),
    .sent_count   (sent_count),
    .clear        (clear),
    .init_credits (init_credits),
    .withhold     (withhold)
  );

  credit_sender #(
    .CREDITS    (CREDITS),
    .MAX_RETURN (MAX_RETURN)
  ) u_sender (
    .clk          (clk),
    .rst          (rst),
    .clear        (clear),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .in_ready     (in_ready),
    .cred_valid   (cred_valid),
    .cred_count   (cred_count),
    .init_credits (init_credits),
    .withhold     (withhold),
    .link_valid   (link_valid),
    .link_data    (link_data),
    .value        (value),
    .available    (available),
    .sent_count   (sent_count)
  );

  // Link has no ready, credits stand in for back-pressure
  credit_receiver #(
    .CREDITS    (CREDITS),
    .MAX_RETURN (MAX_RETURN)
  ) u_receiver (
    .clk        (clk),
    .rst        (rst),
    .clear      (clear),
    .link_valid (link_valid),
    .link_data  (link_data),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .cred_valid (cred_valid),
    .cred_count (cred_count)
  );

endmodule

// File: verification/credit_link_assertions.sv
// Bound twice; each bind ties the inputs it cannot see to values that keep those checks idle
`timescale 1ns/10ps

module credit_link_assertions import credit_link_pkg::*; #(
  parameter int CREDITS    = 8,
  parameter int MAX_RETURN = 4
) (
  input logic    clk,
  input logic    rst,
  input logic    link_valid,
  // Receiver buffer occupancy
  input credit_t fill,
  input logic    cred_valid,
  input change_t cred_count,
  input logic    in_ready,
  input credit_t available
);

  // --------------------------------------------------
  // Link and credit return
  // --------------------------------------------------

  // A flit on the link always has a free slot behind it
  link_no_overrun: assert property (@(posedge clk) disable iff (rst)
    !(link_valid && (fill >= credit_t'(CREDITS))))
    else $error("link flit arrived while the receiver buffer was full");

  // Each batch carries at least one credit and no more than MAX_RETURN
  cred_batch_range: assert property (@(posedge clk) disable iff (rst)
    cred_valid |-> ((cred_count >= change_t'(1)) && (cred_count <= change_t'(MAX_RETURN))))
    else $error("credit return count out of range");

  // Sender must stall once nothing is available
  ready_needs_credit: assert property (@(posedge clk) disable iff (rst)
    (available == '0) |-> !in_ready)
    else $error("in_ready high with no credit available");

endmodule

// Receiver side, the sender-only inputs held quiet
bind credit_receiver credit_link_assertions #(
  .CREDITS    (CREDITS),
  .MAX_RETURN (MAX_RETURN)
) u_rx_checks (
  .clk        (clk),
  .rst        (rst),
  .link_valid (link_valid),
  .fill       (count),
  .cred_valid (cred_valid),
  .cred_count (cred_count),
  .in_ready   (1'b0),
  .available  ('0)
);

// Sender side, buffer fill unknown here
bind credit_sender credit_link_assertions #(
  .CREDITS    (CREDITS),
  .MAX_RETURN (MAX_RETURN)
) u_tx_checks (
  .clk        (clk),
  .rst        (rst),
  .link_valid (link_valid),
  .fill       ('0),
  .cred_valid (cred_valid),
  .cred_count (cred_count),
  .in_ready   (in_ready),
  .available  (available)
);

// File: verification/credit_link_tb.sv
// Credit link testbench; config changes only while idle, stops at the first mismatch
`timescale 1ns/10ps

module credit_link_tb import credit_link_pkg::*; ();

  localparam int CREDITS        = 8;
  localparam int MAX_RETURN     = 4;
  localparam int RESET_CYCLES   = 16;
  localparam int TRAFFIC_CYCLES = 2000;
  localparam int FILL_CYCLES    = 40;
  localparam int DRAIN_LIMIT    = 200;
  localparam int APB_LIMIT      = 8;
  localparam int RETURN_TRIES   = 20;
  // Three traffic phases and five fill phases, doubled by the 40 ns per cycle
  localparam int TEST_CYCLES    = RESET_CYCLES + 3 * TRAFFIC_CYCLES + 5 * FILL_CYCLES;
  localparam int WATCHDOG_NS    = TEST_CYCLES * 40 + 20000;

  logic        clk       = 1'b0;
  logic        rst       = 1'b1;
  logic        psel      = 1'b0;
  logic        penable   = 1'b0;
  logic        pwrite    = 1'b0;
  reg_addr_t   paddr     = '0;
  logic [31:0] pwdata    = '0;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        in_valid  = 1'b0;
  flit_t       in_data   = '0;
  logic        in_ready;
  logic        out_valid;
  flit_t       out_data;
  logic        out_ready = 1'b0;

  // Reference model state
  flit_t       flit_q [$];
  int          sent_model     = 0;
  int          init_model     = CREDITS;
  int          withhold_model = 0;
  logic [31:0] rng_state      = 32'hdbc3;

  credit_link_top #(
    .CREDITS    (CREDITS),
    .MAX_RETURN (MAX_RETURN)
  ) u_dut (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------

  // xorshift32, one step per call
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Most flits in flight: INIT minus WITHHOLD, floored at zero
  function automatic int ceiling_now();
    return (init_model > withhold_model) ? init_model - withhold_model : 0;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got 0x%0h, expected 0x%0h",
                         $time, what, got, exp));
    end
  endtask

  // --------------------------------------------------
  // APB
  // --------------------------------------------------

  // Setup phase, then access phase until pready
  task automatic apb_access(input logic write, input reg_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    waited = 0;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > APB_LIMIT) begin
        fail_run("APB slave never raised pready in the access phase");
      end
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic reg_write(input reg_addr_t addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, data, unused, err);
    check_value(32'(err), 32'd0, $sformatf("pslverr on write to 0x%0h", addr));
  endtask

  task automatic reg_read(input reg_addr_t addr, output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    check_value(32'(err), 32'd0, $sformatf("pslverr on read of 0x%0h", addr));
  endtask

  task automatic set_withhold(input int w);
    reg_write(ADDR_WITHHOLD, 32'(w));
    withhold_model = w;
  endtask

  task automatic set_init(input int n);
    reg_write(ADDR_INIT, 32'(n));
    init_model = n;
  endtask

  // Reload of the sender pool; link must be idle
  task automatic soft_clear();
    reg_write(ADDR_CTRL, 32'd1);
    sent_model = 0;
  endtask

  // --------------------------------------------------
  // Monitor and model
  // --------------------------------------------------

  // Inputs change on the rising edge, so the falling edge sees settled handshakes
  always @(negedge clk) begin
    flit_t head;
    if (!rst) begin
      if (out_valid && out_ready) begin
        if (flit_q.size() == 0) begin
          fail_run($sformatf("ERROR at %0t: flit 0x%0h popped with none expected",
                             $time, out_data));
        end else begin
          head = flit_q.pop_front();
          check_value(32'(out_data), 32'(head), "output flit");
        end
      end
      if (in_valid && in_ready) begin
        flit_q.push_back(in_data);
        sent_model++;
      end
      if (flit_q.size() > ceiling_now()) begin
        fail_run($sformatf("ERROR at %0t: %0d flits in flight above ceiling %0d",
                           $time, flit_q.size(), ceiling_now()));
      end
    end
  end

  // --------------------------------------------------
  // Stimulus phases
  // --------------------------------------------------

  task automatic random_traffic(input int cycles, input int ready_pct);
    logic [31:0] r;
    repeat (cycles) begin
      @(posedge clk);
      r = next_rand();
      in_valid  <= r[0] | r[1];
      in_data   <= r[31:16];
      out_ready <= (int'(r[14:8]) % 100) < ready_pct;
    end
  endtask

  // Consumer stalled, sender offered flits far past the ceiling
  task automatic fill_check(input int expected);
    logic [31:0] r;
    repeat (FILL_CYCLES) begin
      @(posedge clk);
      r = next_rand();
      in_valid  <= 1'b1;
      in_data   <= r[15:0];
      out_ready <= 1'b0;
    end
    @(posedge clk);
    in_valid <= 1'b0;
    @(negedge clk);
    check_value(32'(flit_q.size()), 32'(expected), "flits accepted with out_ready low");
    check_value(32'(in_ready), 32'd0, "in_ready once credits are spent");
  endtask

  // Empties the buffer, then waits for every credit to come home
  task automatic drain_link();
    logic [31:0] rd;
    int          cycles;
    int          tries;
    cycles = 0;
    tries  = 0;
    @(posedge clk);
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    @(negedge clk);
    while (flit_q.size() != 0) begin
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        fail_run("Buffer did not drain: flits still expected at the output");
      end
      @(negedge clk);
    end
    reg_read(ADDR_STATUS, rd);
    while (int'(rd[4:0]) != init_model) begin
      tries++;
      if (tries > RETURN_TRIES) begin
        fail_run("Credits did not all return to the sender after draining");
      end
      reg_read(ADDR_STATUS, rd);
    end
    check_value(32'(rd[12:8]), 32'(ceiling_now()), "STATUS available when idle");
    reg_read(ADDR_SENT, rd);
    check_value(rd, 32'(sent_model), "SENT when idle");
  endtask

  task automatic check_reset_values();
    logic [31:0] rd;
    logic        err;
    @(negedge clk);
    check_value(32'(in_ready), 32'd1, "in_ready after reset");
    reg_read(ADDR_INIT, rd);
    check_value(rd, 32'(CREDITS), "INIT after reset");
    reg_read(ADDR_WITHHOLD, rd);
    check_value(rd, 32'd0, "WITHHOLD after reset");
    reg_read(ADDR_STATUS, rd);
    check_value(32'(rd[4:0]), 32'(CREDITS), "STATUS value after reset");
    check_value(32'(rd[12:8]), 32'(CREDITS), "STATUS available after reset");
    reg_read(ADDR_SENT, rd);
    check_value(rd, 32'd0, "SENT after reset");
    // Hole in the map
    apb_access(1'b0, 8'h14, 32'd0, rd, err);
    check_value(32'(err), 32'd1, "pslverr on unmapped read");
    check_value(rd, 32'd0, "prdata on unmapped read");
  endtask

  // --------------------------------------------------
  // Watchdog and main sequence
  // --------------------------------------------------

  initial begin
    #(WATCHDOG_NS);
    fail_run("Timeout: the run did not finish before the watchdog expired");
  end

  initial begin
    logic [31:0] rd;
    $timeformat(-9, 0, " ns", 0);
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    check_reset_values();

    // Free-running traffic, mostly ready consumer
    random_traffic(TRAFFIC_CYCLES, 75);
    drain_link();

    // Stall ceiling for several withhold amounts
    for (int w = 0; w <= 6; w += 3) begin
      set_withhold(w);
      fill_check(ceiling_now());
      drain_link();
    end

    // Slow consumer with some credits withheld
    set_withhold(2);
    random_traffic(TRAFFIC_CYCLES, 30);
    drain_link();

    // Smaller pool through INIT and a soft clear
    set_init(5);
    soft_clear();
    reg_read(ADDR_SENT, rd);
    check_value(rd, 32'd0, "SENT after soft clear");
    reg_read(ADDR_STATUS, rd);
    check_value(32'(rd[4:0]), 32'(init_model), "STATUS value after soft clear");
    set_withhold(1);
    fill_check(ceiling_now());
    drain_link();
    set_withhold(0);
    fill_check(ceiling_now());
    drain_link();
    random_traffic(TRAFFIC_CYCLES, 60);
    drain_link();

    // Final idle state, all credits back
    reg_read(ADDR_SENT, rd);
    check_value(rd, 32'(sent_model), "final SENT");
    reg_read(ADDR_STATUS, rd);
    check_value(32'(rd[4:0]), 32'(ceiling_now()), "final STATUS value");
    check_value(32'(rd[12:8]), 32'(ceiling_now()), "final STATUS available");

    $display("All tests passed");
    $finish;
  end

endmodule

// File: sim.f
rtl/credit_link_pkg.sv
rtl/credit_counter.sv
rtl/credit_sender.sv
rtl/credit_receiver.sv
rtl/credit_apb_regs.sv
rtl/credit_link_top.sv
verification/credit_link_assertions.sv
verification/credit_link_tb.sv

// File: Makefile
# Verilator build and run of the credit link testbench

VERILATOR ?= verilator
TOP       ?= credit_link_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed

# Every source named in the file list, without the +incdir+ lines
SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass message
run: $(BIN)
	@out="$$($(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
